/* src/hwcnn_pkg.sv */
`default_nettype none

package hwcnn_pkg;

	//////////////////////////////////////////////////////////////////////
	// datapath sizes
	//////////////////////////////////////////////////////////////////////

	localparam int TAPS       = 9;             // 3x3 window
	localparam int PIX_W      = 8;             // signed pixel / weight
	localparam int BEAT_W     = TAPS * PIX_W;  // one memory beat holds one window
	localparam int ACC_W      = 20;            // room for nine 16-bit products
	localparam int INST_LEN   = 64;
	localparam int APP_ADDR_W = 29;            // one address per beat
	localparam int CNT_W      = 8;
	localparam int SHIFT_W    = 5;

	//////////////////////////////////////////////////////////////////////
	// instruction layout, msb first
	//////////////////////////////////////////////////////////////////////

	localparam int OPC_MSB   = 63;
	localparam int OPC_LSB   = 62;
	localparam int RELU_BIT  = 61;
	localparam int SHIFT_MSB = 60;
	localparam int SHIFT_LSB = 56;
	localparam int COUNT_MSB = 55;
	localparam int COUNT_LSB = 48;
	localparam int BUFA_LSB  = 40;             // buf_addr is [47:40]
	localparam int KERA_LSB  = 32;             // ker_addr is [39:32]
	localparam int DDRA_LSB  = 0;              // ddr_addr is [31:0], low 29 used

	typedef enum logic [1:0] {
		op_load_weight  = 2'd0,
		op_load_feature = 2'd1,
		op_conv         = 2'd2,
		op_nop          = 2'd3
	} opcode_t;

	// MIG user interface command codes
	typedef enum logic [2:0] {
		cmd_write = 3'd0,
		cmd_read  = 3'd1
	} mig_cmd_t;

	typedef enum logic [2:0] {
		st_wait_calib,
		st_fetch,
		st_transfer,     // load in progress
		st_conv_run,     // windows still being issued
		st_conv_drain    // last results on their way out
	} ctrl_state_t;

endpackage

`default_nettype wire

/* src/window_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// one window per word, written from memory beats
module window_buffer import hwcnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  wr_en,
	input  logic [BUF_ADDR_W-1:0] wr_addr,
	input  logic [BEAT_W-1:0]     wr_data,
	input  logic                  rd_en,
	input  logic [BUF_ADDR_W-1:0] rd_addr,
	output logic [BEAT_W-1:0]     rd_data
);

	logic [BEAT_W-1:0] mem [0:(2**BUF_ADDR_W)-1];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read port holds its data while rd_en is low
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* src/conv_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_pe import hwcnn_pkg::*; (
	input  logic               clk,
	input  logic               rst,
	input  logic               win_issue,
	input  logic [BEAT_W-1:0]  feature,   // buffer outputs, one cycle after issue
	input  logic [BEAT_W-1:0]  kernel,
	input  logic [SHIFT_W-1:0] shift,
	input  logic               relu,
	input  logic               res_ready,
	output logic               in_ready,
	output logic               res_valid,
	output logic [PIX_W-1:0]   res_data
);

	localparam logic signed [ACC_W-1:0] SAT_MAX = 127;
	localparam logic signed [ACC_W-1:0] SAT_MIN = -128;

	logic                      rd_valid;   // buffer read stage
	logic                      prod_valid;
	logic signed [2*PIX_W-1:0] prod [TAPS];
	logic signed [ACC_W-1:0]   acc;
	logic signed [ACC_W-1:0]   scaled;
	logic signed [ACC_W-1:0]   clamped;
	logic        [PIX_W-1:0]   clipped;

	// whole pipe stalls when the output is stuck
	assign in_ready = !(res_valid && !res_ready);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_valid   <= 1'b0;
			prod_valid <= 1'b0;
			res_valid  <= 1'b0;
		end else if (in_ready) begin
			rd_valid   <= win_issue;
			prod_valid <= rd_valid;
			res_valid  <= prod_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 1 products, stage 2 sum / shift / relu / saturate
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (in_ready) begin
			for (int i = 0; i < TAPS; i++)
				prod[i] <= $signed(feature[i*PIX_W +: PIX_W]) * $signed(kernel[i*PIX_W +: PIX_W]);
		end
	end

	always_comb begin
		acc = '0;
		for (int i = 0; i < TAPS; i++)
			acc = acc + prod[i];
		scaled  = acc >>> shift;   // arithmetic
		clamped = (relu && scaled < 0) ? '0 : scaled;
		if (clamped > SAT_MAX)
			clipped = SAT_MAX[PIX_W-1:0];
		else if (clamped < SAT_MIN)
			clipped = SAT_MIN[PIX_W-1:0];
		else
			clipped = clamped[PIX_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (in_ready)
			res_data <= clipped;
	end

endmodule

`default_nettype wire

/* src/ddr_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_port import hwcnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  opcode_t               op,
	input  logic [APP_ADDR_W-1:0] ddr_addr,
	input  logic [BUF_ADDR_W-1:0] buf_addr,
	input  logic [CNT_W-1:0]      count,
	input  logic                  app_rdy,
	input  logic                  app_wdf_rdy,
	input  logic                  app_rd_data_valid,
	input  logic [BEAT_W-1:0]     app_rd_data,
	input  logic                  res_valid,
	input  logic [PIX_W-1:0]      res_data,
	output logic                  res_ready,
	output logic                  weight_wr_en,
	output logic                  feature_wr_en,
	output logic [BUF_ADDR_W-1:0] buf_wr_addr,
	output logic [BEAT_W-1:0]     buf_wr_data,
	output logic                  app_en,
	output mig_cmd_t              app_cmd,
	output logic [APP_ADDR_W-1:0] app_addr,
	output logic [BEAT_W-1:0]     app_wdf_data,
	output logic                  app_wdf_end,
	output logic                  app_wdf_wren,
	output logic                  done
);

	logic                  busy;
	logic                  wr_mode;      // conv write-back, else a load
	logic                  to_weight;
	logic [CNT_W-1:0]      total;
	logic [CNT_W-1:0]      cmd_cnt;      // read commands accepted
	logic [CNT_W-1:0]      beat_cnt;     // beats returned or results written
	logic [APP_ADDR_W-1:0] cmd_addr;
	logic [BUF_ADDR_W-1:0] buf_ptr;
	logic                  cmd_pend;
	logic                  data_pend;
	logic                  cmd_fire;
	logic                  data_fire;
	logic                  res_fire;
	logic                  rd_beat;
	logic                  wr_complete;
	logic                  finished;

	assign cmd_fire  = app_en && app_rdy;
	assign data_fire = app_wdf_wren && app_wdf_rdy;
	assign res_fire  = res_valid && res_ready;
	assign rd_beat   = busy && !wr_mode && app_rd_data_valid;

	// one result in flight, both handshakes must close before the next
	assign res_ready   = busy && wr_mode && !cmd_pend && !data_pend;
	assign wr_complete = (cmd_pend || data_pend) && (cmd_fire || !cmd_pend)
		&& (data_fire || !data_pend);
	assign finished    = busy && (beat_cnt == total);

	assign app_en       = cmd_pend || (busy && !wr_mode && (cmd_cnt != total));
	assign app_cmd      = wr_mode ? cmd_write : cmd_read;
	assign app_addr     = cmd_addr;
	assign app_wdf_wren = data_pend;
	assign app_wdf_end  = data_pend;   // single beat bursts

	always_ff @(posedge clk) begin
		if (rst) begin
			busy          <= 1'b0;
			done          <= 1'b0;
			cmd_pend      <= 1'b0;
			data_pend     <= 1'b0;
			weight_wr_en  <= 1'b0;
			feature_wr_en <= 1'b0;
			cmd_cnt       <= '0;
			beat_cnt      <= '0;
		end else begin
			done          <= 1'b0;
			weight_wr_en  <= rd_beat && to_weight;
			feature_wr_en <= rd_beat && !to_weight;
			if (start) begin
				busy     <= 1'b1;
				cmd_cnt  <= '0;
				beat_cnt <= '0;
			end else begin
				if (finished) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				if (cmd_fire && !wr_mode)
					cmd_cnt <= cmd_cnt + 1'b1;
				if (rd_beat || wr_complete)
					beat_cnt <= beat_cnt + 1'b1;
			end
			if (cmd_fire)
				cmd_pend <= 1'b0;
			if (data_fire)
				data_pend <= 1'b0;
			if (res_fire) begin
				cmd_pend  <= 1'b1;
				data_pend <= 1'b1;
			end
		end
	end

	// transfer setup, addresses and data
	always_ff @(posedge clk) begin
		if (start) begin
			total     <= count;
			wr_mode   <= (op == op_conv);
			to_weight <= (op == op_load_weight);
			cmd_addr  <= ddr_addr;
			buf_ptr   <= buf_addr;
		end else begin
			if (cmd_fire)
				cmd_addr <= cmd_addr + 1'b1;
			if (rd_beat)
				buf_ptr <= buf_ptr + 1'b1;
		end
		if (rd_beat) begin
			buf_wr_addr <= buf_ptr;
			buf_wr_data <= app_rd_data;
		end
		if (res_fire)
			app_wdf_data <= {{(BEAT_W - PIX_W){1'b0}}, res_data};   // byte in [7:0]
	end

endmodule

`default_nettype wire

/* src/top_control.sv */
`timescale 1ns/1ps
`default_nettype none

module top_control import hwcnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst,

	// instruction FIFO, first word fall through
	input  logic [INST_LEN-1:0]   instruct,
	input  logic                  inst_empty,
	output logic                  inst_req,
	input  logic                  init_calib_complete,

	// transfer engine
	output logic                  start,
	output opcode_t               op,
	output logic [APP_ADDR_W-1:0] ddr_addr,
	output logic [BUF_ADDR_W-1:0] buf_addr,
	output logic [CNT_W-1:0]      count,
	input  logic                  done,

	// conv datapath
	input  logic                  in_ready,
	output logic [BUF_ADDR_W-1:0] weight_rd_addr,
	output logic [BUF_ADDR_W-1:0] feature_rd_addr,
	output logic                  win_issue,
	output logic [SHIFT_W-1:0]    shift,
	output logic                  relu
);

	ctrl_state_t           state;
	opcode_t               inst_op;
	logic [CNT_W-1:0]      issued;     // windows sent so far
	logic [BUF_ADDR_W-1:0] feat_ptr;

	assign inst_op = opcode_t'(instruct[OPC_MSB:OPC_LSB]);

	// fetch only when idle and the memory is up
	assign inst_req = (state == st_fetch) && !inst_empty && init_calib_complete;

	assign win_issue       = (state == st_conv_run) && in_ready && (issued != count);
	assign feature_rd_addr = feat_ptr;

	//////////////////////////////////////////////////////////////////////
	// instruction fields, held for the whole instruction
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (inst_req) begin
			op             <= inst_op;
			relu           <= instruct[RELU_BIT];
			shift          <= instruct[SHIFT_MSB:SHIFT_LSB];
			count          <= instruct[COUNT_MSB:COUNT_LSB];
			buf_addr       <= instruct[BUFA_LSB +: BUF_ADDR_W];
			weight_rd_addr <= instruct[KERA_LSB +: BUF_ADDR_W];   // one kernel per conv
			ddr_addr       <= instruct[DDRA_LSB +: APP_ADDR_W];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// sequencing FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_wait_calib;
			start    <= 1'b0;
			issued   <= '0;
			feat_ptr <= '0;
		end else begin
			start <= 1'b0;
			case (state)
				st_wait_calib: begin
					if (init_calib_complete)
						state <= st_fetch;
				end
				st_fetch: begin
					if (inst_req) begin
						issued   <= '0;
						feat_ptr <= instruct[BUFA_LSB +: BUF_ADDR_W];
						case (inst_op)
							op_nop: begin
								state <= st_fetch;      // dropped, fetch again next cycle
							end
							op_conv: begin
								start <= 1'b1;          // arms the write side of ddr_port
								state <= st_conv_run;
							end
							default: begin
								start <= 1'b1;
								state <= st_transfer;
							end
						endcase
					end
				end
				st_transfer: begin
					if (done)
						state <= st_fetch;
				end
				st_conv_run: begin
					if (win_issue) begin
						issued   <= issued + 1'b1;
						feat_ptr <= feat_ptr + 1'b1;
					end
					if (issued == count)
						state <= st_conv_drain;
				end
				st_conv_drain: begin
					if (done)
						state <= st_fetch;  // last write accepted
				end
				default: state <= st_wait_calib;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/hwcnn_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hwcnn_top import hwcnn_pkg::*; #(
	parameter int BUF_ADDR_W = 8
) (
	input  logic                  clk,
	input  logic                  rst,

	input  logic [INST_LEN-1:0]   instruct,
	output logic                  inst_req,
	input  logic                  inst_empty,

	// MIG user interface
	input  logic                  init_calib_complete,
	input  logic                  app_rdy,
	input  logic                  app_wdf_rdy,
	input  logic                  app_rd_data_valid,
	input  logic [BEAT_W-1:0]     app_rd_data,
	output mig_cmd_t              app_cmd,
	output logic [APP_ADDR_W-1:0] app_addr,
	output logic                  app_en,
	output logic [BEAT_W-1:0]     app_wdf_data,
	output logic                  app_wdf_end,
	output logic                  app_wdf_wren
);

	logic                  start;
	logic                  done;
	opcode_t               op;
	logic [APP_ADDR_W-1:0] ddr_addr;
	logic [BUF_ADDR_W-1:0] buf_addr;
	logic [CNT_W-1:0]      count;
	logic [BUF_ADDR_W-1:0] weight_rd_addr;
	logic [BUF_ADDR_W-1:0] feature_rd_addr;
	logic                  win_issue;
	logic [SHIFT_W-1:0]    shift;
	logic                  relu;
	logic                  in_ready;
	logic                  res_valid;
	logic                  res_ready;
	logic [PIX_W-1:0]      res_data;
	logic                  weight_wr_en;
	logic                  feature_wr_en;
	logic [BUF_ADDR_W-1:0] buf_wr_addr;
	logic [BEAT_W-1:0]     buf_wr_data;
	logic [BEAT_W-1:0]     kernel_win;
	logic [BEAT_W-1:0]     feature_win;

	//////////////////////////////////////////////////////////////////////
	// control and memory port
	//////////////////////////////////////////////////////////////////////

	top_control #(.BUF_ADDR_W(BUF_ADDR_W)) i_top_control (
		.clk(clk), .rst(rst),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.init_calib_complete(init_calib_complete),
		.start(start), .op(op), .ddr_addr(ddr_addr), .buf_addr(buf_addr),
		.count(count), .done(done), .in_ready(in_ready),
		.weight_rd_addr(weight_rd_addr), .feature_rd_addr(feature_rd_addr),
		.win_issue(win_issue), .shift(shift), .relu(relu)
	);

	ddr_port #(.BUF_ADDR_W(BUF_ADDR_W)) i_ddr_port (
		.clk(clk), .rst(rst),
		.start(start), .op(op), .ddr_addr(ddr_addr), .buf_addr(buf_addr), .count(count),
		.app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data),
		.res_valid(res_valid), .res_data(res_data), .res_ready(res_ready),
		.weight_wr_en(weight_wr_en), .feature_wr_en(feature_wr_en),
		.buf_wr_addr(buf_wr_addr), .buf_wr_data(buf_wr_data),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_data(app_wdf_data), .app_wdf_end(app_wdf_end),
		.app_wdf_wren(app_wdf_wren), .done(done)
	);

	//////////////////////////////////////////////////////////////////////
	// buffers and MAC pipe, reads advance with in_ready
	//////////////////////////////////////////////////////////////////////

	window_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) i_weight_buffer (
		.clk(clk), .wr_en(weight_wr_en), .wr_addr(buf_wr_addr), .wr_data(buf_wr_data),
		.rd_en(in_ready), .rd_addr(weight_rd_addr), .rd_data(kernel_win)
	);

	window_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) i_feature_buffer (
		.clk(clk), .wr_en(feature_wr_en), .wr_addr(buf_wr_addr), .wr_data(buf_wr_data),
		.rd_en(in_ready), .rd_addr(feature_rd_addr), .rd_data(feature_win)
	);

	conv_pe i_conv_pe (
		.clk(clk), .rst(rst), .win_issue(win_issue),
		.feature(feature_win), .kernel(kernel_win), .shift(shift), .relu(relu),
		.res_ready(res_ready), .in_ready(in_ready),
		.res_valid(res_valid), .res_data(res_data)
	);

endmodule

`default_nettype wire

/* test/hwcnn_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// interface rules of the FIFO and MIG user ports
module hwcnn_checker import hwcnn_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  inst_req,
	input  logic                  inst_empty,
	input  logic                  init_calib_complete,
	input  logic                  app_en,
	input  logic                  app_rdy,
	input  mig_cmd_t              app_cmd,
	input  logic [APP_ADDR_W-1:0] app_addr,
	input  logic                  app_wdf_wren,
	input  logic                  app_wdf_rdy,
	input  logic                  app_wdf_end,
	input  logic [BEAT_W-1:0]     app_wdf_data
);

	int fail_cnt = 0;   // failed assertions so far

	a_fetch_gate: assert property (@(posedge clk) disable iff (rst)
		inst_req |-> !inst_empty && init_calib_complete)
		else begin fail_cnt++; $error("inst_req with empty FIFO or no calibration"); end

	a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr))
		else begin fail_cnt++; $error("command channel changed before app_rdy"); end

	a_wdf_hold: assert property (@(posedge clk) disable iff (rst)
		app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data))
		else begin fail_cnt++; $error("write data changed before app_wdf_rdy"); end

	// one beat per burst
	a_wdf_end: assert property (@(posedge clk) disable iff (rst)
		app_wdf_end == app_wdf_wren)
		else begin fail_cnt++; $error("app_wdf_end differs from app_wdf_wren"); end

endmodule

bind hwcnn_top hwcnn_checker i_checker (.*);

`default_nettype wire

/* test/hwcnn_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hwcnn_tb import hwcnn_pkg::*; ();

	localparam int TIMEOUT = 5000;   // cycles per wait

	logic                  clk = 1'b0;
	logic                  rst;
	logic [INST_LEN-1:0]   instruct;
	logic                  inst_req;
	logic                  inst_empty;
	logic                  init_calib_complete;
	logic                  app_rdy;
	logic                  app_wdf_rdy;
	logic                  app_rd_data_valid;
	logic [BEAT_W-1:0]     app_rd_data;
	mig_cmd_t              app_cmd;
	logic [APP_ADDR_W-1:0] app_addr;
	logic                  app_en;
	logic [BEAT_W-1:0]     app_wdf_data;
	logic                  app_wdf_end;
	logic                  app_wdf_wren;

	logic [BEAT_W-1:0]     mem [0:255];     // external memory with one beat per address
	logic [BEAT_W-1:0]     wbuf_m [0:255];  // expected buffer contents
	logic [BEAT_W-1:0]     fbuf_m [0:255];
	logic [INST_LEN-1:0]   inst_q [$];
	mig_cmd_t              cmd_q [$];
	logic [APP_ADDR_W-1:0] addr_q [$];
	logic [BEAT_W-1:0]     wdata_q [$];
	logic [7:0]            rd_idx_q [$];
	int                    rd_due_q [$];
	int                    cyc = 0;
	int                    last_due = 0;
	logic                  stall_mode = 1'b0;
	logic [31:0]           rng_state = 32'd23798;

	hwcnn_top #(.BUF_ADDR_W(8)) i_hwcnn_top (.*);

	always #2 clk = ~clk;

	function automatic logic [15:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[30:15];
	endfunction

	function automatic logic [INST_LEN-1:0] make_inst(opcode_t op, logic relu, logic [4:0] sh,
		logic [7:0] n, logic [7:0] buf_a, logic [7:0] ker, logic [31:0] ddr);
		return {op, relu, sh, n, buf_a, ker, ddr};
	endfunction

	// sum of products, arithmetic shift, optional relu, clip to signed 8 bits
	function automatic logic [PIX_W-1:0] conv_ref(logic [BEAT_W-1:0] f, logic [BEAT_W-1:0] k,
		int sh, logic relu);
		int sum;
		sum = 0;
		for (int i = 0; i < TAPS; i++)
			sum += $signed(f[i*PIX_W +: PIX_W]) * $signed(k[i*PIX_W +: PIX_W]);
		sum = sum >>> sh;
		if (relu && sum < 0)
			sum = 0;
		if (sum > 127)
			sum = 127;
		else if (sum < -128)
			sum = -128;
		return sum[PIX_W-1:0];
	endfunction

	////////////////////////////////////////////////////////////////////
	// memory and FIFO model
	////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : mem_model
		int due;
		if (!rst) begin
			if (inst_req && !inst_empty)
				void'(inst_q.pop_front());
			if (app_en && app_rdy) begin
				cmd_q.push_back(app_cmd);
				addr_q.push_back(app_addr);
				if (app_cmd == cmd_read) begin
					due = cyc + 2 + int'(lcg_next() % 5);   // 2 to 6 cycles later and in order
					if (due <= last_due)
						due = last_due + 1;
					last_due = due;
					rd_idx_q.push_back(app_addr[7:0]);
					rd_due_q.push_back(due);
				end
			end
			if (app_wdf_wren && app_wdf_rdy)
				wdata_q.push_back(app_wdf_data);
		end
		cyc++;
		#0.5;
		inst_empty  = (inst_q.size() == 0);
		instruct    = (inst_q.size() == 0) ? '0 : inst_q[0];
		app_rdy     = stall_mode ? (lcg_next() % 3 != 0) : 1'b1;
		app_wdf_rdy = stall_mode ? (lcg_next() % 3 != 0) : 1'b1;
		if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
			void'(rd_due_q.pop_front());
			app_rd_data_valid = 1'b1;
			app_rd_data       = mem[rd_idx_q.pop_front()];
		end else begin
			app_rd_data_valid = 1'b0;
			app_rd_data       = '0;
		end
	end

	////////////////////////////////////////////////////////////////////
	// checks and waits
	////////////////////////////////////////////////////////////////////

	task automatic stop_run(string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// a failed interface assertion ends the run right away
	always @(negedge clk) begin
		if (i_hwcnn_top.i_checker.fail_cnt != 0)
			stop_run("an interface assertion failed");
	end

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp));
	endtask

	task automatic check_result(string name, logic [PIX_W-1:0] got, logic [PIX_W-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name,
				$signed(got), $signed(exp)));
	endtask

	task automatic check_addr(string name, logic [APP_ADDR_W-1:0] got,
		logic [APP_ADDR_W-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
	endtask

	task automatic check_cmd(string name, mig_cmd_t got, mig_cmd_t exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH t=%0t %s got=%s exp=%s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic wait_traffic(int n_cmd, int n_beat, string what);
		int t;
		t = 0;
		while ((cmd_q.size() < n_cmd || wdata_q.size() < n_beat) && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (cmd_q.size() < n_cmd || wdata_q.size() < n_beat)
			stop_run({"timeout waiting for memory traffic of ", what});
	endtask

	task automatic wait_fifo_empty(string what);
		int t;
		t = 0;
		while (inst_q.size() != 0 && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (inst_q.size() != 0)
			stop_run({"timeout waiting for the DUT to fetch ", what});
	endtask

	////////////////////////////////////////////////////////////////////
	// instruction tasks
	////////////////////////////////////////////////////////////////////

	task automatic run_load(opcode_t op, int ddr, int buf_a, int n);
		@(negedge clk);
		inst_q.push_back(make_inst(op, 1'b0, 5'd0, n, buf_a, 8'd0, ddr));
		for (int k = 0; k < n; k++) begin
			if (op == op_load_weight)
				wbuf_m[buf_a + k] = mem[ddr + k];
			else
				fbuf_m[buf_a + k] = mem[ddr + k];
		end
		wait_traffic(n, 0, "a load");
		for (int k = 0; k < n; k++) begin
			check_cmd("app_cmd", cmd_q.pop_front(), cmd_read);
			check_addr("app_addr", addr_q.pop_front(), ddr + k);
		end
	endtask

	task automatic run_conv(int ker, int buf_a, int n, int sh, logic relu, int ddr);
		logic [BEAT_W-1:0] beat;
		@(negedge clk);
		inst_q.push_back(make_inst(op_conv, relu, sh, n, buf_a, ker, ddr));
		wait_traffic(n, n, "a conv");
		for (int k = 0; k < n; k++) begin
			beat = wdata_q.pop_front();
			check_cmd("app_cmd", cmd_q.pop_front(), cmd_write);
			check_addr("app_addr", addr_q.pop_front(), ddr + k);
			check_result("app_wdf_data[7:0]", beat[PIX_W-1:0],
				conv_ref(fbuf_m[buf_a + k], wbuf_m[ker], sh, relu));
			if (beat[BEAT_W-1:PIX_W] != '0)
				stop_run("write beat has nonzero bits above the result byte");
		end
	endtask

	////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////

	task automatic test_calib_hold();
		@(negedge clk);
		check_bit("inst_req", inst_req, 1'b0);
		check_bit("app_en", app_en, 1'b0);
		check_bit("app_wdf_wren", app_wdf_wren, 1'b0);
		inst_q.push_back(make_inst(op_nop, 1'b0, 5'd0, 8'd0, 8'd0, 8'd0, 32'd0));
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			if (inst_q.size() != 1)
				stop_run("instruction consumed before memory calibration completed");
		end
		@(posedge clk);
		#0.5;
		init_calib_complete = 1'b1;
		wait_fifo_empty("a nop after calibration");
	endtask

	task automatic test_conv_plain();
		run_load(op_load_weight, 0, 0, 2);
		run_load(op_load_feature, 16, 0, 8);
		run_conv(0, 0, 8, 0, 1'b0, 100);
	endtask

	task automatic test_shift_relu();
		logic signed [PIX_W-1:0] vals [6] = '{8'sd100, 8'sd10, -8'sd50, -8'sd1, 8'sd14, 8'sd15};
		mem[2] = {TAPS{8'sd16}};   // scale 16 cancels shift 4
		for (int i = 0; i < 6; i++)
			mem[32 + i] = {TAPS{vals[i]}};
		run_load(op_load_weight, 2, 2, 1);
		run_load(op_load_feature, 32, 8, 6);
		run_conv(2, 8, 6, 4, 1'b1, 130);
	endtask

	task automatic test_backpressure();
		@(negedge clk);
		stall_mode = 1'b1;
		run_load(op_load_feature, 16, 0, 8);
		run_conv(0, 0, 8, 0, 1'b0, 100);
		run_conv(1, 0, 8, 3, 1'b0, 100);
		@(negedge clk);
		stall_mode = 1'b0;
	endtask

	task automatic test_nop_keeps_buffers();
		int t;
		run_load(op_load_weight, 4, 5, 1);
		@(negedge clk);
		inst_q.push_back(make_inst(op_nop, 1'b0, 5'd0, 8'd8, 8'd0, 8'd0, 32'd200));
		wait_fifo_empty("a nop between loads");
		for (t = 0; t < 20; t++) begin
			@(negedge clk);
			if (cmd_q.size() != 0)
				stop_run("memory command issued for a nop");
		end
		run_load(op_load_feature, 40, 20, 4);
		run_conv(1, 0, 8, 2, 1'b0, 150);
		run_conv(5, 20, 4, 1, 1'b1, 170);
	endtask

	initial begin
		rst                 = 1'b1;
		instruct            = '0;
		inst_empty          = 1'b1;
		init_calib_complete = 1'b0;
		app_rdy             = 1'b0;
		app_wdf_rdy         = 1'b0;
		app_rd_data_valid   = 1'b0;
		app_rd_data         = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = {lcg_next(), lcg_next(), lcg_next(), lcg_next(), lcg_next()};
		repeat (16) @(posedge clk);
		#0.5;
		rst = 1'b0;

		test_calib_hold();
		test_conv_plain();
		test_shift_relu();
		test_backpressure();
		test_nop_keeps_buffers();

		wait_fifo_empty("the last instruction");
		if (cmd_q.size() != 0 || wdata_q.size() != 0)
			stop_run("unexpected memory traffic after the last instruction");
		if (i_hwcnn_top.i_checker.fail_cnt == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("interface assertions failed during the run");
			$display("TEST FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

/* compile.f */
src/hwcnn_pkg.sv
src/window_buffer.sv
src/conv_pe.sv
src/ddr_port.sv
src/top_control.sv
src/hwcnn_top.sv
test/hwcnn_checker.sv
test/hwcnn_tb.sv
